//--- rtl/periph_pkg.sv
package periph_pkg;

   //************************************************************
   // Bus and register widths
   //************************************************************
   localparam int DATA_W    = 32;
   localparam int ADR_W     = 16;
   localparam int REG_IDX_W = 4;

   // Address fields
   localparam int IDX_LSB   = 2;
   localparam int SLV_LSB   = 6;
   localparam int SLV_W     = 3;

   //************************************************************
   // Peripheral counts
   //************************************************************
   localparam int GPIO_W       = 32;
   localparam int PWM_CHANNELS = 3;
   localparam int IRQ_SRC_W    = 1 + PWM_CHANNELS;

   // Slave select, codes 5 to 7 unmapped
   typedef enum logic [SLV_W-1:0] {
      SLV_GPIO = 3'd0,
      SLV_IRQ  = 3'd1,
      SLV_PWM0 = 3'd2,
      SLV_PWM1 = 3'd3,
      SLV_PWM2 = 3'd4
   } slave_e;

   typedef enum logic [REG_IDX_W-1:0] {
      GPIO_IN      = 4'd0,
      GPIO_OUT     = 4'd1,
      GPIO_OE      = 4'd2,
      GPIO_RISE_EN = 4'd3
   } gpio_reg_e;

   typedef enum logic [REG_IDX_W-1:0] {
      PWM_CTRL = 4'd0,
      PWM_HRC  = 4'd1,
      PWM_LRC  = 4'd2,
      PWM_CNT  = 4'd3
   } pwm_reg_e;

   typedef enum logic [REG_IDX_W-1:0] {
      IRQ_PENDING = 4'd0,
      IRQ_ENABLE  = 4'd1
   } irq_reg_e;

endpackage

//--- rtl/periph_bus_ctrl.sv
`timescale 1ns/1ps

module periph_bus_ctrl (
   input  logic                                                  i_clk,
   input  logic                                                  i_rst,
   input  logic [periph_pkg::ADR_W-1:0]                          i_wb_adr,
   input  logic [periph_pkg::DATA_W-1:0]                         i_wb_dat,
   input  logic                                                  i_wb_we,
   input  logic                                                  i_wb_cyc,
   input  logic                                                  i_wb_stb,
   output logic [periph_pkg::DATA_W-1:0]                         o_wb_rdt,
   output logic                                                  o_wb_ack,
   output logic                                                  o_wb_err,
   input  logic [periph_pkg::DATA_W-1:0]                         i_gpio_rdt,
   input  logic [periph_pkg::DATA_W-1:0]                         i_irq_rdt,
   input  logic [periph_pkg::PWM_CHANNELS-1:0][periph_pkg::DATA_W-1:0] i_pwm_rdt,
   output logic [periph_pkg::REG_IDX_W-1:0]                      o_r_idx,
   output logic [periph_pkg::DATA_W-1:0]                         o_w_dat,
   output logic                                                  o_gpio_we,
   output logic                                                  o_irq_we,
   output logic [periph_pkg::PWM_CHANNELS-1:0]                   o_pwm_we
);
   import periph_pkg::*;

   slave_e              slv;
   logic                mapped;
   logic                req;
   logic                wr_req;
   logic [DATA_W-1:0]   rdt_mux;

   assign slv     = slave_e'(i_wb_adr[SLV_LSB +: SLV_W]);
   assign o_r_idx = i_wb_adr[IDX_LSB +: REG_IDX_W];
   assign o_w_dat = i_wb_dat;

   // New request only once the previous one has been answered
   assign req    = i_wb_cyc & i_wb_stb & ~o_wb_ack & ~o_wb_err;
   assign wr_req = req & mapped & i_wb_we;

   always_comb begin
      mapped  = 1'b1;
      rdt_mux = '0;
      case (slv)
         SLV_GPIO: rdt_mux = i_gpio_rdt;
         SLV_IRQ:  rdt_mux = i_irq_rdt;
         SLV_PWM0: rdt_mux = i_pwm_rdt[0];
         SLV_PWM1: rdt_mux = i_pwm_rdt[1];
         SLV_PWM2: rdt_mux = i_pwm_rdt[2];
         default:  mapped = 1'b0;
      endcase
      // Anything above the slave field is outside the map
      if (i_wb_adr[ADR_W-1:SLV_LSB+SLV_W] != '0)
         mapped = 1'b0;
   end

   //************************************************************
   // Acknowledge, error and write strobes
   //************************************************************
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_wb_ack  <= 1'b0;
         o_wb_err  <= 1'b0;
         o_gpio_we <= 1'b0;
         o_irq_we  <= 1'b0;
         o_pwm_we  <= '0;
      end else begin
         o_wb_ack  <= req & mapped;
         o_wb_err  <= req & ~mapped;
         o_gpio_we <= wr_req & (slv == SLV_GPIO);
         o_irq_we  <= wr_req & (slv == SLV_IRQ);
         o_pwm_we  <= {wr_req & (slv == SLV_PWM2),
                       wr_req & (slv == SLV_PWM1),
                       wr_req & (slv == SLV_PWM0)};
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_rst)
         o_wb_rdt <= '0;
      else if (req & mapped)
         o_wb_rdt <= rdt_mux;
   end

   ack_err_excl: assert property (@(posedge i_clk) disable iff (i_rst)
      !(o_wb_ack && o_wb_err));

   ack_one_cycle: assert property (@(posedge i_clk) disable iff (i_rst)
      o_wb_ack |=> !o_wb_ack);

endmodule

//--- rtl/gpio_port.sv
`timescale 1ns/1ps

module gpio_port (
   input  logic                             i_clk,
   input  logic                             i_rst,
   input  logic [periph_pkg::REG_IDX_W-1:0] i_r_idx,
   input  logic [periph_pkg::DATA_W-1:0]    i_w_dat,
   input  logic                             i_we,
   input  logic [periph_pkg::GPIO_W-1:0]    i_gpio,
   output logic [periph_pkg::DATA_W-1:0]    o_rdt,
   output logic [periph_pkg::GPIO_W-1:0]    o_gpio,
   output logic [periph_pkg::GPIO_W-1:0]    o_gpio_oe,
   output logic                             o_edge
);
   import periph_pkg::*;

   logic [GPIO_W-1:0] rise_en;
   logic [GPIO_W-1:0] sync_q1;
   logic [GPIO_W-1:0] sync_q2;
   logic [GPIO_W-1:0] in_prev;

   // Register reads
   always_comb begin
      case (gpio_reg_e'(i_r_idx))
         GPIO_IN:      o_rdt = DATA_W'(sync_q2);
         GPIO_OUT:     o_rdt = DATA_W'(o_gpio);
         GPIO_OE:      o_rdt = DATA_W'(o_gpio_oe);
         GPIO_RISE_EN: o_rdt = DATA_W'(rise_en);
         default:      o_rdt = '0;
      endcase
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_gpio    <= '0;
         o_gpio_oe <= '0;
         rise_en   <= '0;
      end else if (i_we) begin
         case (gpio_reg_e'(i_r_idx))
            GPIO_OUT:     o_gpio    <= i_w_dat[GPIO_W-1:0];
            GPIO_OE:      o_gpio_oe <= i_w_dat[GPIO_W-1:0];
            GPIO_RISE_EN: rise_en   <= i_w_dat[GPIO_W-1:0];
            default:      ;
         endcase
      end
   end

   //************************************************************
   // Input synchroniser and edge detect
   //************************************************************
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         sync_q1 <= '0;
         sync_q2 <= '0;
         in_prev <= '0;
         o_edge  <= 1'b0;
      end else begin
         sync_q1 <= i_gpio;
         sync_q2 <= sync_q1;
         in_prev <= sync_q2;
         // Any enabled pin going high
         o_edge  <= |(sync_q2 & ~in_prev & rise_en);
      end
   end

endmodule

//--- rtl/pwm_timer.sv
`timescale 1ns/1ps

module pwm_timer (
   input  logic                             i_clk,
   input  logic                             i_rst,
   input  logic [periph_pkg::REG_IDX_W-1:0] i_r_idx,
   input  logic [periph_pkg::DATA_W-1:0]    i_w_dat,
   input  logic                             i_we,
   output logic [periph_pkg::DATA_W-1:0]    o_rdt,
   output logic                             o_pwm,
   output logic                             o_wrap
);
   import periph_pkg::*;

   logic              ctrl_en;
   logic [DATA_W-1:0] hrc;
   logic [DATA_W-1:0] lrc;
   logic [DATA_W-1:0] cnt;
   logic              run;
   logic              last_cnt;
   logic              lrc_we;

   assign run      = ctrl_en && (lrc != '0);
   assign last_cnt = (cnt >= lrc - DATA_W'(1));
   assign lrc_we   = i_we && (pwm_reg_e'(i_r_idx) == PWM_LRC);

   // High for the first HRC counts of each period
   assign o_pwm = ctrl_en && (cnt < hrc);

   always_comb begin
      case (pwm_reg_e'(i_r_idx))
         PWM_CTRL: o_rdt = DATA_W'(ctrl_en);
         PWM_HRC:  o_rdt = hrc;
         PWM_LRC:  o_rdt = lrc;
         PWM_CNT:  o_rdt = cnt;
         default:  o_rdt = '0;
      endcase
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         ctrl_en <= 1'b0;
         hrc     <= '0;
         lrc     <= '0;
      end else if (i_we) begin
         case (pwm_reg_e'(i_r_idx))
            PWM_CTRL: ctrl_en <= i_w_dat[0];
            PWM_HRC:  hrc     <= i_w_dat;
            PWM_LRC:  lrc     <= i_w_dat;
            default:  ;
         endcase
      end
   end

   //************************************************************
   // Period counter
   //************************************************************
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         cnt    <= '0;
         o_wrap <= 1'b0;
      end else begin
         o_wrap <= run && last_cnt;
         // Held at zero while stopped
         if (!run || last_cnt)
            cnt <= '0;
         else
            cnt <= cnt + DATA_W'(1);
      end
   end

   cnt_in_period: assert property (@(posedge i_clk) disable iff (i_rst)
      (run && !lrc_we) |=> (cnt < lrc));

endmodule

//--- rtl/irq_ctrl.sv
`timescale 1ns/1ps

module irq_ctrl (
   input  logic                             i_clk,
   input  logic                             i_rst,
   input  logic [periph_pkg::REG_IDX_W-1:0] i_r_idx,
   input  logic [periph_pkg::DATA_W-1:0]    i_w_dat,
   input  logic                             i_we,
   input  logic [periph_pkg::IRQ_SRC_W-1:0] i_src,
   output logic [periph_pkg::DATA_W-1:0]    o_rdt,
   output logic                             o_irq
);
   import periph_pkg::*;

   logic [IRQ_SRC_W-1:0] pending;
   logic [IRQ_SRC_W-1:0] enable;
   logic [IRQ_SRC_W-1:0] pending_nxt;
   logic [IRQ_SRC_W-1:0] enable_nxt;
   logic [IRQ_SRC_W-1:0] clr;

   always_comb begin
      case (irq_reg_e'(i_r_idx))
         IRQ_PENDING: o_rdt = DATA_W'(pending);
         IRQ_ENABLE:  o_rdt = DATA_W'(enable);
         default:     o_rdt = '0;
      endcase
   end

   always_comb begin
      clr        = '0;
      enable_nxt = enable;
      if (i_we) begin
         case (irq_reg_e'(i_r_idx))
            IRQ_PENDING: clr        = i_w_dat[IRQ_SRC_W-1:0];
            IRQ_ENABLE:  enable_nxt = i_w_dat[IRQ_SRC_W-1:0];
            default:     ;
         endcase
      end
      // A new pulse beats a clear in the same cycle
      pending_nxt = (pending & ~clr) | i_src;
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         pending <= '0;
         enable  <= '0;
         o_irq   <= 1'b0;
      end else begin
         pending <= pending_nxt;
         enable  <= enable_nxt;
         o_irq   <= |(pending_nxt & enable_nxt);
      end
   end

endmodule

//--- rtl/periph_top.sv
`timescale 1ns/1ps

module periph_top (
   input  logic                                i_clk,
   input  logic                                i_rst,
   input  logic [periph_pkg::ADR_W-1:0]        i_wb_adr,
   input  logic [periph_pkg::DATA_W-1:0]       i_wb_dat,
   input  logic                                i_wb_we,
   input  logic                                i_wb_cyc,
   input  logic                                i_wb_stb,
   output logic [periph_pkg::DATA_W-1:0]       o_wb_rdt,
   output logic                                o_wb_ack,
   output logic                                o_wb_err,
   input  logic [periph_pkg::GPIO_W-1:0]       i_gpio,
   output logic [periph_pkg::GPIO_W-1:0]       o_gpio,
   output logic [periph_pkg::GPIO_W-1:0]       o_gpio_oe,
   output logic [periph_pkg::PWM_CHANNELS-1:0] o_pwm,
   output logic                                o_irq
);
   import periph_pkg::*;

   logic [REG_IDX_W-1:0]                   r_idx;
   logic [DATA_W-1:0]                      w_dat;
   logic                                   gpio_we;
   logic                                   irq_we;
   logic [PWM_CHANNELS-1:0]                pwm_we;
   logic [DATA_W-1:0]                      gpio_rdt;
   logic [DATA_W-1:0]                      irq_rdt;
   logic [PWM_CHANNELS-1:0][DATA_W-1:0]    pwm_rdt;
   logic                                   gpio_edge;
   logic [PWM_CHANNELS-1:0]                pwm_wrap;

   periph_bus_ctrl u_bus_ctrl (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .i_wb_adr   (i_wb_adr),
      .i_wb_dat   (i_wb_dat),
      .i_wb_we    (i_wb_we),
      .i_wb_cyc   (i_wb_cyc),
      .i_wb_stb   (i_wb_stb),
      .o_wb_rdt   (o_wb_rdt),
      .o_wb_ack   (o_wb_ack),
      .o_wb_err   (o_wb_err),
      .i_gpio_rdt (gpio_rdt),
      .i_irq_rdt  (irq_rdt),
      .i_pwm_rdt  (pwm_rdt),
      .o_r_idx    (r_idx),
      .o_w_dat    (w_dat),
      .o_gpio_we  (gpio_we),
      .o_irq_we   (irq_we),
      .o_pwm_we   (pwm_we)
   );

   gpio_port u_gpio (
      .i_clk     (i_clk),
      .i_rst     (i_rst),
      .i_r_idx   (r_idx),
      .i_w_dat   (w_dat),
      .i_we      (gpio_we),
      .i_gpio    (i_gpio),
      .o_rdt     (gpio_rdt),
      .o_gpio    (o_gpio),
      .o_gpio_oe (o_gpio_oe),
      .o_edge    (gpio_edge)
   );

   // Former red, green and blue LED timers
   for (genvar ch = 0; ch < PWM_CHANNELS; ch++) begin : g_pwm
      pwm_timer u_pwm (
         .i_clk   (i_clk),
         .i_rst   (i_rst),
         .i_r_idx (r_idx),
         .i_w_dat (w_dat),
         .i_we    (pwm_we[ch]),
         .o_rdt   (pwm_rdt[ch]),
         .o_pwm   (o_pwm[ch]),
         .o_wrap  (pwm_wrap[ch])
      );
   end

   // Source 0 is GPIO, then one per PWM channel
   irq_ctrl u_irq (
      .i_clk   (i_clk),
      .i_rst   (i_rst),
      .i_r_idx (r_idx),
      .i_w_dat (w_dat),
      .i_we    (irq_we),
      .i_src   ({pwm_wrap, gpio_edge}),
      .o_rdt   (irq_rdt),
      .o_irq   (o_irq)
   );

endmodule

//--- verification/periph_tb.sv
`timescale 1ns/1ps

module periph_tb;
   import periph_pkg::*;

   localparam string       PATTERN_FILE    = "verification/periph_patterns.txt";
   localparam int          BUS_TIMEOUT     = 20;
   localparam int          WATCHDOG_CYCLES = 100000;
   localparam logic [15:0] LFSR_SEED       = 16'd56889;

   logic                    i_clk;
   logic                    i_rst;
   logic [ADR_W-1:0]        i_wb_adr;
   logic [DATA_W-1:0]       i_wb_dat;
   logic                    i_wb_we;
   logic                    i_wb_cyc;
   logic                    i_wb_stb;
   logic [DATA_W-1:0]       o_wb_rdt;
   logic                    o_wb_ack;
   logic                    o_wb_err;
   logic [GPIO_W-1:0]       i_gpio;
   logic [GPIO_W-1:0]       o_gpio;
   logic [GPIO_W-1:0]       o_gpio_oe;
   logic [PWM_CHANNELS-1:0] o_pwm;
   logic                    o_irq;
   logic [15:0]             lfsr_state;

   periph_top UUT (
      .i_clk     (i_clk),
      .i_rst     (i_rst),
      .i_wb_adr  (i_wb_adr),
      .i_wb_dat  (i_wb_dat),
      .i_wb_we   (i_wb_we),
      .i_wb_cyc  (i_wb_cyc),
      .i_wb_stb  (i_wb_stb),
      .o_wb_rdt  (o_wb_rdt),
      .o_wb_ack  (o_wb_ack),
      .o_wb_err  (o_wb_err),
      .i_gpio    (i_gpio),
      .o_gpio    (o_gpio),
      .o_gpio_oe (o_gpio_oe),
      .o_pwm     (o_pwm),
      .o_irq     (o_irq)
   );

   always #2 i_clk = ~i_clk;

   //************************************************************
   // Random data and address helpers
   //************************************************************
   // Taps for x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic lfsr_bit();
      logic fb;
      fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
      lfsr_state = {lfsr_state[14:0], fb};
      return fb;
   endfunction

   function automatic logic [DATA_W-1:0] rand_word();
      logic [DATA_W-1:0] w;
      int                i;
      w = '0;
      for (i = 0; i < DATA_W; i++)
         w = {w[DATA_W-2:0], lfsr_bit()};
      return w;
   endfunction

   // Slave code in bits 8 to 6, register index in bits 5 to 2
   function automatic logic [ADR_W-1:0] reg_adr(input slave_e slv,
                                                input logic [REG_IDX_W-1:0] idx);
      return ADR_W'({slv, idx, 2'b00});
   endfunction

   //************************************************************
   // Error reporting and compare tasks
   //************************************************************
   task automatic abort_run();
      $display("sim failed");
      $fatal(1, "Stopped at the first error");
   endtask

   task automatic report_problem(input string msg);
      $display("%s (time %0t)", msg, $time);
      abort_run();
   endtask

   task automatic check_word(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                             input string what);
      if (got !== exp) begin
         $display("FAILED at time %0t: %s got %h expected %h", $time, what, got, exp);
         abort_run();
      end
   endtask

   task automatic check_bit(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         $display("FAILED at time %0t: %s got %b expected %b", $time, what, got, exp);
         abort_run();
      end
   endtask

   task automatic check_slave(input slave_e got, input slave_e exp, input string what);
      if (got !== exp) begin
         $display("FAILED at time %0t: %s got slave %0d expected slave %0d",
                  $time, what, got, exp);
         abort_run();
      end
   endtask

   //************************************************************
   // Wishbone master
   //************************************************************
   task automatic bus_access(input logic [ADR_W-1:0] adr, input logic we,
                             input logic [DATA_W-1:0] wdat,
                             output logic [DATA_W-1:0] rdat,
                             output logic ack, output logic err);
      int waited;
      waited = 0;
      @(negedge i_clk);
      i_wb_adr = adr;
      i_wb_dat = wdat;
      i_wb_we  = we;
      i_wb_cyc = 1'b1;
      i_wb_stb = 1'b1;
      do begin
         @(negedge i_clk);
         waited++;
      end while (!o_wb_ack && !o_wb_err && waited < BUS_TIMEOUT);
      if (!o_wb_ack && !o_wb_err)
         report_problem($sformatf("No ack or err within %0d cycles for address %h",
                                  BUS_TIMEOUT, adr));
      rdat = o_wb_rdt;
      ack  = o_wb_ack;
      err  = o_wb_err;
      // Drop the strobe for at least one cycle
      i_wb_cyc = 1'b0;
      i_wb_stb = 1'b0;
      i_wb_we  = 1'b0;
   endtask

   task automatic access_ok(input logic [ADR_W-1:0] adr, input logic we,
                            input logic [DATA_W-1:0] wdat, output logic [DATA_W-1:0] rdat);
      logic ack;
      logic err;
      bus_access(adr, we, wdat, rdat, ack, err);
      check_bit(ack, 1'b1, $sformatf("ack for address %h", adr));
      check_bit(err, 1'b0, $sformatf("err for address %h", adr));
   endtask

   task automatic expect_error(input logic [ADR_W-1:0] adr, input logic we,
                               input logic [DATA_W-1:0] wdat);
      logic [DATA_W-1:0] rdat;
      logic              ack;
      logic              err;
      bus_access(adr, we, wdat, rdat, ack, err);
      check_bit(ack, 1'b0, $sformatf("ack for unmapped address %h", adr));
      check_bit(err, 1'b1, $sformatf("err for unmapped address %h", adr));
   endtask

   //************************************************************
   // Pattern operations
   //************************************************************
   task automatic random_readback(input int count);
      logic [DATA_W-1:0] d_out;
      logic [DATA_W-1:0] d_oe;
      logic [DATA_W-1:0] rd;
      int                k;
      for (k = 0; k < count; k++) begin
         d_out = rand_word();
         d_oe  = rand_word();
         access_ok(reg_adr(SLV_GPIO, GPIO_OUT), 1'b1, d_out, rd);
         check_slave(UUT.u_bus_ctrl.slv, SLV_GPIO, "GPIO slave decode");
         access_ok(reg_adr(SLV_GPIO, GPIO_OE), 1'b1, d_oe, rd);
         access_ok(reg_adr(SLV_GPIO, GPIO_OUT), 1'b0, '0, rd);
         check_word(rd, d_out, "GPIO_OUT readback");
         access_ok(reg_adr(SLV_GPIO, GPIO_OE), 1'b0, '0, rd);
         check_word(rd, d_oe, "GPIO_OE readback");
         check_word(o_gpio, d_out, "o_gpio pins");
         check_word(o_gpio_oe, d_oe, "o_gpio_oe pins");
      end
   endtask

   task automatic measure_pwm(input int ch, input logic [DATA_W-1:0] hrc,
                              input logic [DATA_W-1:0] lrc);
      slave_e            slv;
      logic [DATA_W-1:0] rd;
      logic [DATA_W-1:0] high_len;
      logic [DATA_W-1:0] pos;
      int                waited;
      slv      = slave_e'(SLV_W'(int'(SLV_PWM0) + ch));
      // Constant high once HRC reaches the period
      high_len = (hrc >= lrc) ? lrc : hrc;
      access_ok(reg_adr(slv, PWM_CTRL), 1'b1, '0, rd);
      check_slave(UUT.u_bus_ctrl.slv, slv, $sformatf("PWM%0d slave decode", ch));
      access_ok(reg_adr(slv, PWM_HRC), 1'b1, hrc, rd);
      access_ok(reg_adr(slv, PWM_LRC), 1'b1, lrc, rd);
      access_ok(reg_adr(slv, PWM_CTRL), 1'b1, DATA_W'(1), rd);
      waited = 0;
      if (hrc != '0) begin
         while (o_pwm[ch] !== 1'b1 && waited < 2 * int'(lrc) + BUS_TIMEOUT) begin
            @(negedge i_clk);
            waited++;
         end
         if (o_pwm[ch] !== 1'b1)
            report_problem($sformatf("PWM channel %0d never went high", ch));
      end
      // Two full periods from the rising edge
      for (pos = '0; pos < 2 * lrc; pos++) begin
         check_bit(o_pwm[ch], (pos % lrc) < high_len,
                   $sformatf("PWM%0d level at step %0d", ch, pos));
         @(negedge i_clk);
      end
   endtask

   task automatic run_op(input logic [7:0] op, input logic [DATA_W-1:0] fa,
                         input logic [DATA_W-1:0] fb, input logic [DATA_W-1:0] fc);
      logic [DATA_W-1:0] rd;
      case (op)
         "W": access_ok(ADR_W'(fa), 1'b1, fb, rd);
         "R": begin
            access_ok(ADR_W'(fa), 1'b0, '0, rd);
            check_word(rd, fb, $sformatf("Read of address %h", ADR_W'(fa)));
         end
         "E": expect_error(ADR_W'(fa), fb[0], fc);
         "G": begin
            @(negedge i_clk);
            i_gpio = fa;
            // Two sync flops, the edge flop, then the IRQ flop
            repeat (4) @(negedge i_clk);
         end
         "Q": begin
            @(negedge i_clk);
            check_bit(o_irq, fa[0], "o_irq level");
         end
         "D": measure_pwm(int'(fa), fb, fc);
         "X": random_readback(int'(fa));
         default: report_problem($sformatf("Unknown operation %c in the pattern file", op));
      endcase
   endtask

   //************************************************************
   // Main sequence
   //************************************************************
   initial begin : main
      int                fd;
      int                n;
      string             line;
      logic [7:0]        op;
      logic [DATA_W-1:0] fa;
      logic [DATA_W-1:0] fb;
      logic [DATA_W-1:0] fc;
      i_clk      = 1'b0;
      i_rst      = 1'b1;
      i_wb_adr   = '0;
      i_wb_dat   = '0;
      i_wb_we    = 1'b0;
      i_wb_cyc   = 1'b0;
      i_wb_stb   = 1'b0;
      i_gpio     = '0;
      lfsr_state = LFSR_SEED;
      repeat (5) @(negedge i_clk);
      i_rst = 1'b0;
      @(negedge i_clk);
      check_bit(o_wb_ack, 1'b0, "o_wb_ack after reset");
      check_bit(o_wb_err, 1'b0, "o_wb_err after reset");
      check_bit(o_irq, 1'b0, "o_irq after reset");
      check_word(o_wb_rdt, '0, "o_wb_rdt after reset");
      check_word(o_gpio_oe, '0, "o_gpio_oe after reset");
      check_word(DATA_W'(o_pwm), '0, "o_pwm after reset");

      fd = $fopen(PATTERN_FILE, "r");
      if (fd == 0)
         report_problem("Cannot open the pattern file");
      while ($fgets(line, fd) != 0) begin
         n = $sscanf(line, " %c %h %h %h", op, fa, fb, fc);
         if (n >= 1 && op != "#") begin
            if (n != 4)
               report_problem($sformatf("Pattern line needs four fields: %s", line));
            run_op(op, fa, fb, fc);
         end
      end
      $fclose(fd);

      $display("sim passed");
      $finish;
   end

   initial begin : watchdog
      repeat (WATCHDOG_CYCLES) @(posedge i_clk);
      $display("Simulation did not finish within %0d cycles", WATCHDOG_CYCLES);
      $display("sim failed");
      $fatal(1, "Watchdog expired");
   end

endmodule

//--- verification/periph_patterns.txt
# op  a  b  c, all hex, unused fields 0
# W adr data | R adr expect | E adr we data | G gpio_in | Q irq | D ch hrc lrc | X count
X 00000010 0 0
G A5A50F0E 0 0
R 00000000 A5A50F0E 0
E 00000140 0 0
E 00000180 1 FFFFFFFF
E 000001C0 0 0
E 00000200 0 0
E 00000244 1 00000001
R 00000044 00000000 0
G 5A5AF0F0 0 0
R 00000000 5A5AF0F0 0
W 0000000C 00000001 0
R 0000000C 00000001 0
G 00000000 0 0
R 00000040 00000000 0
Q 0 0 0
G 00000001 0 0
R 00000040 00000001 0
Q 0 0 0
W 00000044 00000001 0
Q 1 0 0
W 00000040 00000001 0
Q 0 0 0
R 00000040 00000000 0
G 00000000 0 0
G 00000002 0 0
R 00000040 00000000 0
Q 0 0 0
D 0 3 8
R 00000084 00000003 0
R 00000088 00000008 0
W 00000080 00000000 0
R 00000080 00000000 0
R 0000008C 00000000 0
R 00000040 00000002 0
W 00000040 0000000F 0
R 00000040 00000000 0
D 1 5 6
R 00000040 00000004 0
W 00000044 00000004 0
Q 1 0 0
W 000000C0 00000000 0
R 000000C0 00000000 0
R 000000CC 00000000 0
W 00000040 0000000F 0
Q 0 0 0
D 2 0 A
R 00000040 00000008 0
D 2 C A
W 00000100 00000000 0
R 00000100 00000000 0
R 0000010C 00000000 0
W 00000040 0000000F 0
R 00000040 00000000 0
Q 0 0 0

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module periph_tb \
   -f files.f -o periph_sim

# The log is kept even when the simulation stops on an error
./obj_dir/periph_sim | tee sim.log

if grep -qx "sim passed" sim.log; then
   echo "Simulation result: PASS"
else
   echo "Simulation result: FAIL"
   exit 1
fi

//--- files.f
rtl/periph_pkg.sv
rtl/periph_bus_ctrl.sv
rtl/gpio_port.sv
rtl/pwm_timer.sv
rtl/irq_ctrl.sv
rtl/periph_top.sv
verification/periph_tb.sv
